// File: legalizer_pkg.sv
// Widths, page size and vector types shared by the burst legalizer
`default_nettype none

package legalizer_pkg;

    // ------------------------------------------------------------------------
    // Bus and transfer sizes
    // ------------------------------------------------------------------------
    // Word-wide data path on both sides
    localparam int unsigned DataWidth     = 32;
    localparam int unsigned AddrWidth     = 24;
    localparam int unsigned LenWidth      = 16;
    // Bytes per word and byte offset bits
    localparam int unsigned StrbWidth     = DataWidth / 8;
    localparam int unsigned OffsetWidth   = $clog2(StrbWidth);
    // One page is 256 words
    localparam int unsigned PageSize      = 256 * StrbWidth;
    localparam int unsigned PageAddrWidth = $clog2(PageSize);

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    typedef logic [AddrWidth-1:0]   addr_t;
    typedef logic [LenWidth-1:0]    len_t;
    // Up to a full page, so one bit wider than the page offset
    typedef logic [PageAddrWidth:0] page_len_t;
    typedef logic [OffsetWidth-1:0] offset_t;
    // AXI len field, beats minus one
    typedef logic [7:0]             beats_t;

endpackage

`default_nettype wire

// File: burst_tracker.sv
// One side's remaining transfer state and its next page-legal burst
`default_nettype none

module burst_tracker import legalizer_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    // New transfer
    input  logic      load_i,
    input  addr_t     addr_i,
    input  len_t      length_i,
    // Step to next burst, or drop everything
    input  logic      advance_i,
    input  logic      kill_i,
    // Largest burst allowed this cycle
    input  page_len_t limit_i,
    // Current burst
    output addr_t     addr_o,
    output offset_t   start_offset_o,
    output page_len_t num_bytes_o,
    output page_len_t to_page_o,
    output logic      done_o,
    output logic      busy_o
);

    addr_t   addr_q;
    len_t    len_q;
    logic    busy_q;
    offset_t start_off_q;
    logic    over_limit;

    // ------------------------------------------------------------------------
    // Burst size
    // ------------------------------------------------------------------------
    // Bytes left before the next page boundary
    assign to_page_o = page_len_t'(PageSize) - {1'b0, addr_q[PageAddrWidth-1:0]};

    // More left than fits, so cut at the limit
    assign over_limit  = len_q > len_t'(limit_i);
    assign num_bytes_o = over_limit ? limit_i : len_q[PageAddrWidth:0];

    // Idle counts as done so a new request can enter
    assign done_o = ~busy_q | ~over_limit;

    assign addr_o         = addr_q;
    assign start_offset_o = start_off_q;
    assign busy_o         = busy_q;

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            len_q  <= '0;
            busy_q <= 1'b0;
        end else if (load_i) begin
            len_q  <= length_i;
            busy_q <= 1'b1;
        end else if (kill_i) begin
            len_q  <= '0;
            busy_q <= 1'b0;
        end else if (advance_i && busy_q) begin
            // Last burst leaves the side idle
            len_q  <= over_limit ? len_q - len_t'(num_bytes_o) : '0;
            busy_q <= over_limit;
        end
    end

    // Address and start offset of the active transfer
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q      <= addr_i;
            start_off_q <= addr_i[OffsetWidth-1:0];
        end else if (advance_i && busy_q && over_limit) begin
            addr_q <= addr_q + addr_t'(num_bytes_o);
        end
    end

endmodule

`default_nettype wire

// File: legalizer_ctrl.sv
// Request acceptance, coupling of both sides, flush and kill handling
`default_nettype none

module legalizer_ctrl import legalizer_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    // Request handshake
    input  logic      valid_i,
    input  logic      decouple_i,
    output logic      ready_o,
    output logic      load_o,
    // Downstream readiness and overrides
    input  logic      r_ready_i,
    input  logic      w_ready_i,
    input  logic      flush_i,
    input  logic      kill_i,
    // Tracker status
    input  page_len_t r_to_page_i,
    input  page_len_t w_to_page_i,
    input  logic      r_done_i,
    input  logic      w_done_i,
    input  logic      r_busy_i,
    input  logic      w_busy_i,
    // Tracker control
    output page_len_t r_limit_o,
    output page_len_t w_limit_o,
    output logic      r_advance_o,
    output logic      w_advance_o,
    // Burst strobes
    output logic      r_valid_o,
    output logic      w_valid_o
);

    logic      decouple_q;
    page_len_t c_to_page;
    logic      r_go;
    logic      w_go;

    // ------------------------------------------------------------------------
    // Acceptance
    // ------------------------------------------------------------------------
    // Kill counts as done on both sides
    assign ready_o = (r_done_i | kill_i) & (w_done_i | kill_i)
                   & r_ready_i & w_ready_i & ~flush_i;
    assign load_o  = valid_i & ready_o;

    // Mode of the active transfer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            decouple_q <= 1'b0;
        end else if (load_o) begin
            decouple_q <= decouple_i;
        end
    end

    // ------------------------------------------------------------------------
    // Coupling
    // ------------------------------------------------------------------------
    // Closer boundary of the two
    assign c_to_page = (r_to_page_i > w_to_page_i) ? w_to_page_i : r_to_page_i;
    assign r_limit_o = decouple_q ? r_to_page_i : c_to_page;
    assign w_limit_o = decouple_q ? w_to_page_i : c_to_page;

    // Coupled mode stalls both sides when either ready is low
    assign r_go = r_ready_i & ~flush_i & (decouple_q | w_ready_i);
    assign w_go = w_ready_i & ~flush_i & (decouple_q | r_ready_i);

    assign r_advance_o = r_go | kill_i;
    assign w_advance_o = w_go | kill_i;

    assign r_valid_o = r_busy_i & r_go;
    assign w_valid_o = w_busy_i & w_go;

endmodule

`default_nettype wire

// File: obi_read_request.sv
// OBI read burst fields from the read tracker state
`default_nettype none

module obi_read_request import legalizer_pkg::*; (
    input  addr_t     addr_i,
    input  page_len_t num_bytes_i,
    input  offset_t   start_offset_i,
    output addr_t     r_addr_o,
    output offset_t   r_offset_o,
    output offset_t   r_tailer_o,
    output offset_t   r_shift_o,
    output logic      r_single_o
);

    page_len_t end_bytes;

    // ------------------------------------------------------------------------
    // Address and byte lanes
    // ------------------------------------------------------------------------
    // Word aligned request address
    assign r_addr_o   = {addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
    assign r_offset_o = addr_i[OffsetWidth-1:0];

    // Byte lane after the last valid byte
    assign end_bytes  = num_bytes_i + page_len_t'(r_offset_o);
    assign r_tailer_o = end_bytes[OffsetWidth-1:0];

    // Read shifter aligns on the source start offset
    assign r_shift_o = start_offset_i;

    // At most one word of payload
    assign r_single_o = num_bytes_i <= page_len_t'(StrbWidth);

endmodule

`default_nettype wire

// File: axi_write_request.sv
// AXI write burst fields from the write tracker state
`default_nettype none

module axi_write_request import legalizer_pkg::*; (
    input  addr_t     addr_i,
    input  page_len_t num_bytes_i,
    input  offset_t   start_offset_i,
    input  logic      done_i,
    output addr_t     w_addr_o,
    output beats_t    w_len_o,
    output offset_t   w_offset_o,
    output offset_t   w_tailer_o,
    output offset_t   w_shift_o,
    output logic      w_single_o,
    output logic      w_last_o
);

    page_len_t end_bytes;
    page_len_t last_byte;

    // ------------------------------------------------------------------------
    // AW channel
    // ------------------------------------------------------------------------
    // Word aligned, size is always one full word
    assign w_addr_o   = {addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
    assign w_offset_o = addr_i[OffsetWidth-1:0];

    // Index of last byte touched, counted from the aligned address
    assign end_bytes = num_bytes_i + page_len_t'(w_offset_o);
    assign last_byte = end_bytes - page_len_t'(1);

    // Beats minus one; never above 255 within a page
    assign w_len_o = beats_t'(last_byte >> OffsetWidth);

    // ------------------------------------------------------------------------
    // Write data path
    // ------------------------------------------------------------------------
    assign w_tailer_o = end_bytes[OffsetWidth-1:0];
    // Undo the destination misalignment
    assign w_shift_o  = -start_offset_i;
    assign w_single_o = w_len_o == '0;

    // Final burst of the 1D transfer
    assign w_last_o = done_i;

endmodule

`default_nettype wire

// File: idma_legalizer.sv
// Burst legalizer top level with controller, trackers and request formers
`default_nettype none

module idma_legalizer import legalizer_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    // 1D transfer request
    input  addr_t   src_addr_i,
    input  addr_t   dst_addr_i,
    input  len_t    length_i,
    input  logic    decouple_i,
    input  logic    valid_i,
    output logic    ready_o,
    // Downstream readiness and overrides
    input  logic    r_ready_i,
    input  logic    w_ready_i,
    input  logic    flush_i,
    input  logic    kill_i,
    // OBI read burst
    output addr_t   r_addr_o,
    output offset_t r_offset_o,
    output offset_t r_tailer_o,
    output offset_t r_shift_o,
    output logic    r_single_o,
    // AXI write burst
    output addr_t   w_addr_o,
    output beats_t  w_len_o,
    output offset_t w_offset_o,
    output offset_t w_tailer_o,
    output offset_t w_shift_o,
    output logic    w_single_o,
    output logic    w_last_o,
    // Strobes and status
    output logic    r_valid_o,
    output logic    w_valid_o,
    output logic    r_busy_o,
    output logic    w_busy_o
);

    logic      load;
    page_len_t r_limit, w_limit;
    page_len_t r_to_page, w_to_page;
    page_len_t r_num_bytes, w_num_bytes;
    logic      r_advance, w_advance;
    logic      r_done, w_done;
    addr_t     r_addr, w_addr;
    offset_t   r_start_off, w_start_off;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    legalizer_ctrl i_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .decouple_i  (decouple_i),
        .ready_o     (ready_o),
        .load_o      (load),
        .r_ready_i   (r_ready_i),
        .w_ready_i   (w_ready_i),
        .flush_i     (flush_i),
        .kill_i      (kill_i),
        .r_to_page_i (r_to_page),
        .w_to_page_i (w_to_page),
        .r_done_i    (r_done),
        .w_done_i    (w_done),
        .r_busy_i    (r_busy_o),
        .w_busy_i    (w_busy_o),
        .r_limit_o   (r_limit),
        .w_limit_o   (w_limit),
        .r_advance_o (r_advance),
        .w_advance_o (w_advance),
        .r_valid_o   (r_valid_o),
        .w_valid_o   (w_valid_o)
    );

    // ------------------------------------------------------------------------
    // Source side, OBI read
    // ------------------------------------------------------------------------
    burst_tracker i_read_tracker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .load_i         (load),
        .addr_i         (src_addr_i),
        .length_i       (length_i),
        .advance_i      (r_advance),
        .kill_i         (kill_i),
        .limit_i        (r_limit),
        .addr_o         (r_addr),
        .start_offset_o (r_start_off),
        .num_bytes_o    (r_num_bytes),
        .to_page_o      (r_to_page),
        .done_o         (r_done),
        .busy_o         (r_busy_o)
    );

    obi_read_request i_read_request (
        .addr_i         (r_addr),
        .num_bytes_i    (r_num_bytes),
        .start_offset_i (r_start_off),
        .r_addr_o       (r_addr_o),
        .r_offset_o     (r_offset_o),
        .r_tailer_o     (r_tailer_o),
        .r_shift_o      (r_shift_o),
        .r_single_o     (r_single_o)
    );

    // ------------------------------------------------------------------------
    // Destination side, AXI write
    // ------------------------------------------------------------------------
    burst_tracker i_write_tracker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .load_i         (load),
        .addr_i         (dst_addr_i),
        .length_i       (length_i),
        .advance_i      (w_advance),
        .kill_i         (kill_i),
        .limit_i        (w_limit),
        .addr_o         (w_addr),
        .start_offset_o (w_start_off),
        .num_bytes_o    (w_num_bytes),
        .to_page_o      (w_to_page),
        .done_o         (w_done),
        .busy_o         (w_busy_o)
    );

    axi_write_request i_write_request (
        .addr_i         (w_addr),
        .num_bytes_i    (w_num_bytes),
        .start_offset_i (w_start_off),
        .done_i         (w_done),
        .w_addr_o       (w_addr_o),
        .w_len_o        (w_len_o),
        .w_offset_o     (w_offset_o),
        .w_tailer_o     (w_tailer_o),
        .w_shift_o      (w_shift_o),
        .w_single_o     (w_single_o),
        .w_last_o       (w_last_o)
    );

endmodule

`default_nettype wire

// File: legalizer_checker.sv
// Concurrent assertions on strobes, flush and page-legal burst sizes
`default_nettype none

module legalizer_checker import legalizer_pkg::*; (
    input logic      clk_i,
    input logic      rst_i,
    input logic      flush_i,
    input logic      r_valid_i,
    input logic      w_valid_i,
    input logic      r_busy_i,
    input logic      w_busy_i,
    // Burst size and page distance inside the DUT
    input page_len_t r_num_bytes_i,
    input page_len_t w_num_bytes_i,
    input page_len_t r_to_page_i,
    input page_len_t w_to_page_i
);

    timeunit 1ns;
    timeprecision 1ns;

    // Number of failed assertions
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // Strobe rules
    // ------------------------------------------------------------------------
    // Flush holds every burst
    no_strobe_in_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |-> !(r_valid_i || w_valid_i))
        else begin
            fail_count++;
            $error("burst strobe while flush is high");
        end

    // A side only emits while it has work
    read_strobe_needs_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_i |-> r_busy_i)
        else begin
            fail_count++;
            $error("read burst while the read side is idle");
        end

    write_strobe_needs_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        w_valid_i |-> w_busy_i)
        else begin
            fail_count++;
            $error("write burst while the write side is idle");
        end

    // ------------------------------------------------------------------------
    // Page rule
    // ------------------------------------------------------------------------
    read_within_page: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_i |-> r_num_bytes_i <= r_to_page_i)
        else begin
            fail_count++;
            $error("read burst crosses a page boundary");
        end

    write_within_page: assert property (@(posedge clk_i) disable iff (rst_i)
        w_valid_i |-> w_num_bytes_i <= w_to_page_i)
        else begin
            fail_count++;
            $error("write burst crosses a page boundary");
        end

endmodule

`default_nettype wire

// File: legalizer_monitor.sv
// Reference model of the legalizer and the burst by burst comparison
`default_nettype none

module legalizer_monitor import legalizer_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  int      test_id_i,
    // Request side
    input  addr_t   src_addr_i,
    input  addr_t   dst_addr_i,
    input  len_t    length_i,
    input  logic    decouple_i,
    input  logic    valid_i,
    input  logic    ready_i,
    input  logic    r_ready_i,
    input  logic    w_ready_i,
    input  logic    flush_i,
    input  logic    kill_i,
    // Read burst
    input  addr_t   r_addr_i,
    input  offset_t r_offset_i,
    input  offset_t r_tailer_i,
    input  offset_t r_shift_i,
    input  logic    r_single_i,
    // Write burst
    input  addr_t   w_addr_i,
    input  beats_t  w_len_i,
    input  offset_t w_offset_i,
    input  offset_t w_tailer_i,
    input  offset_t w_shift_i,
    input  logic    w_single_i,
    input  logic    w_last_i,
    // Strobes and status
    input  logic    r_valid_i,
    input  logic    w_valid_i,
    input  logic    r_busy_i,
    input  logic    w_busy_i,
    output int      errors_o,
    output int      reads_o,
    output int      writes_o
);

    timeunit 1ns;
    timeprecision 1ns;

    // Model of the active transfer
    addr_t   m_r_addr, m_w_addr;
    int      m_r_len, m_w_len;
    offset_t m_r_start, m_w_start;
    logic    m_r_act, m_w_act, m_dec;
    int      errors = 0;
    int      reads = 0;
    int      writes = 0;

    assign errors_o = errors;
    assign reads_o  = reads;
    assign writes_o = writes;

    // ------------------------------------------------------------------------
    // Reference functions
    // ------------------------------------------------------------------------
    function automatic string test_name(int id);
        case (id)
            1: return "single_burst";
            2: return "coupled_split";
            3: return "decoupled_backpressure";
            4: return "coupled_backpressure";
            5: return "flush";
            6: return "kill";
            default: return "reset";
        endcase
    endfunction

    // Bytes left up to the next page boundary
    function automatic int page_distance(addr_t addr);
        return PageSize - int'(addr % PageSize);
    endfunction

    // Cut at the limit if more is left
    function automatic int burst_bytes(int remaining, int limit);
        return (remaining > limit) ? limit : remaining;
    endfunction

    // {addr, offset, tailer, shift, single}
    function automatic logic [30:0] read_fields(addr_t addr, int bytes, offset_t start);
        int off;
        off = int'(addr) % StrbWidth;
        return {addr_t'(int'(addr) - off), offset_t'(off),
                offset_t'((bytes + off) % StrbWidth), start, bytes <= StrbWidth};
    endfunction

    // {addr, beats-1, offset, tailer, shift, single, last}
    function automatic logic [39:0] write_fields(addr_t addr, int bytes, offset_t start,
                                                 logic last);
        int off;
        int beats;
        off   = int'(addr) % StrbWidth;
        beats = (bytes + off - 1) / StrbWidth;
        return {addr_t'(int'(addr) - off), beats_t'(beats), offset_t'(off),
                offset_t'((bytes + off) % StrbWidth),
                offset_t'((StrbWidth - int'(start)) % StrbWidth), beats == 0, last};
    endfunction

    task automatic note_failure(string what);
        errors++;
        $display("ERROR in %s at %0t: %s", test_name(test_id_i), $time, what);
    endtask

    task automatic value_mismatch(string what, logic [39:0] expected, logic [39:0] actual);
        errors++;
        $display("MISMATCH %s %s expected %h actual %h at %0t",
                 test_name(test_id_i), what, expected, actual, $time);
    endtask

    // ------------------------------------------------------------------------
    // Compare at every edge, then step the model
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        int          r_lim, w_lim, r_bytes, w_bytes;
        logic        r_go, w_go, exp_rv, exp_wv;
        logic        r_last, w_last, exp_ready;
        logic [30:0] r_exp;
        logic [39:0] w_exp;
        if (rst_i) begin
            m_r_act  = 1'b0;
            m_w_act  = 1'b0;
            m_dec    = 1'b0;
            m_r_addr = '0;
            m_w_addr = '0;
            m_r_len  = 0;
            m_w_len  = 0;
        end else begin
            // Coupled sides share the closer boundary
            r_lim = page_distance(m_r_addr);
            w_lim = page_distance(m_w_addr);
            if (!m_dec) begin
                r_lim = (r_lim < w_lim) ? r_lim : w_lim;
                w_lim = r_lim;
            end
            r_bytes = burst_bytes(m_r_len, r_lim);
            w_bytes = burst_bytes(m_w_len, w_lim);
            r_go    = r_ready_i && !flush_i && (m_dec || w_ready_i);
            w_go    = w_ready_i && !flush_i && (m_dec || r_ready_i);
            exp_rv  = m_r_act && r_go;
            exp_wv  = m_w_act && w_go;
            r_last  = !m_r_act || m_r_len <= r_lim;
            w_last  = !m_w_act || m_w_len <= w_lim;
            exp_ready = ((r_last && w_last) || kill_i) && r_ready_i && w_ready_i && !flush_i;

            if (ready_i !== exp_ready)
                value_mismatch("ready_o", 40'(exp_ready), 40'(ready_i));
            if (r_busy_i !== m_r_act)
                note_failure(m_r_act ? "read side not busy during a transfer"
                                     : "read busy still high after the transfer");
            if (w_busy_i !== m_w_act)
                note_failure(m_w_act ? "write side not busy during a transfer"
                                     : "write busy still high after the transfer");

            // Read burst
            if (r_valid_i !== exp_rv) begin
                note_failure(exp_rv ? "missing read burst" : "read burst not expected");
            end else if (exp_rv) begin
                reads++;
                r_exp = read_fields(m_r_addr, r_bytes, m_r_start);
                if ({r_addr_i, r_offset_i, r_tailer_i, r_shift_i, r_single_i} !== r_exp)
                    value_mismatch("read burst", 40'(r_exp),
                        40'({r_addr_i, r_offset_i, r_tailer_i, r_shift_i, r_single_i}));
            end

            // Write burst
            if (w_valid_i !== exp_wv) begin
                note_failure(exp_wv ? "missing write burst" : "write burst not expected");
            end else if (exp_wv) begin
                writes++;
                w_exp = write_fields(m_w_addr, w_bytes, m_w_start, w_last);
                if ({w_addr_i, w_len_i, w_offset_i, w_tailer_i, w_shift_i, w_single_i,
                     w_last_i} !== w_exp)
                    value_mismatch("write burst", w_exp, {w_addr_i, w_len_i, w_offset_i,
                        w_tailer_i, w_shift_i, w_single_i, w_last_i});
            end

            // New request wins over kill
            if (valid_i && exp_ready) begin
                m_r_addr  = src_addr_i;
                m_w_addr  = dst_addr_i;
                m_r_len   = int'(length_i);
                m_w_len   = int'(length_i);
                m_r_start = offset_t'(int'(src_addr_i) % StrbWidth);
                m_w_start = offset_t'(int'(dst_addr_i) % StrbWidth);
                m_r_act   = 1'b1;
                m_w_act   = 1'b1;
                m_dec     = decouple_i;
            end else if (kill_i) begin
                m_r_act = 1'b0;
                m_w_act = 1'b0;
            end else begin
                if (exp_rv) begin
                    if (m_r_len > r_lim) begin
                        m_r_addr = m_r_addr + addr_t'(r_lim);
                        m_r_len  = m_r_len - r_lim;
                    end else begin
                        m_r_act = 1'b0;
                    end
                end
                if (exp_wv) begin
                    if (m_w_len > w_lim) begin
                        m_w_addr = m_w_addr + addr_t'(w_lim);
                        m_w_len  = m_w_len - w_lim;
                    end else begin
                        m_w_act = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_legalizer.sv
// Testbench top with clock, reset, stimulus, watchdog and closing line
`default_nettype none

module tb_legalizer import legalizer_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int ClkPeriod    = 100;
    localparam int MaxLength    = 3000;
    localparam int NumTransfers = 17;
    // Each transfer gets its word count plus slack four times over
    localparam int TimeoutCycles = NumTransfers * (MaxLength / StrbWidth + 8) * 4;

    logic    clk;
    logic    rst;
    addr_t   src_addr, dst_addr;
    len_t    length;
    logic    decouple, valid, ready;
    logic    r_ready = 1'b0;
    logic    w_ready = 1'b0;
    logic    flush, kill;
    addr_t   r_addr, w_addr;
    offset_t r_offset, r_tailer, r_shift;
    offset_t w_offset, w_tailer, w_shift;
    beats_t  w_len;
    logic    r_single, w_single, w_last;
    logic    r_valid, w_valid, r_busy, w_busy;
    // Ready pattern control
    logic    shake, ready_level;
    int      test_id;
    int      errors, reads, writes;

    // ------------------------------------------------------------------------
    // DUT, monitor and assertions
    // ------------------------------------------------------------------------
    idma_legalizer dut (
        .clk_i (clk), .rst_i (rst),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr),
        .length_i (length), .decouple_i (decouple),
        .valid_i (valid), .ready_o (ready),
        .r_ready_i (r_ready), .w_ready_i (w_ready),
        .flush_i (flush), .kill_i (kill),
        .r_addr_o (r_addr), .r_offset_o (r_offset), .r_tailer_o (r_tailer),
        .r_shift_o (r_shift), .r_single_o (r_single),
        .w_addr_o (w_addr), .w_len_o (w_len), .w_offset_o (w_offset),
        .w_tailer_o (w_tailer), .w_shift_o (w_shift), .w_single_o (w_single),
        .w_last_o (w_last),
        .r_valid_o (r_valid), .w_valid_o (w_valid),
        .r_busy_o (r_busy), .w_busy_o (w_busy)
    );

    legalizer_monitor i_monitor (
        .clk_i (clk), .rst_i (rst), .test_id_i (test_id),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr),
        .length_i (length), .decouple_i (decouple),
        .valid_i (valid), .ready_i (ready),
        .r_ready_i (r_ready), .w_ready_i (w_ready),
        .flush_i (flush), .kill_i (kill),
        .r_addr_i (r_addr), .r_offset_i (r_offset), .r_tailer_i (r_tailer),
        .r_shift_i (r_shift), .r_single_i (r_single),
        .w_addr_i (w_addr), .w_len_i (w_len), .w_offset_i (w_offset),
        .w_tailer_i (w_tailer), .w_shift_i (w_shift), .w_single_i (w_single),
        .w_last_i (w_last),
        .r_valid_i (r_valid), .w_valid_i (w_valid),
        .r_busy_i (r_busy), .w_busy_i (w_busy),
        .errors_o (errors), .reads_o (reads), .writes_o (writes)
    );

    bind idma_legalizer legalizer_checker i_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .r_valid_i     (r_valid_o),
        .w_valid_i     (w_valid_o),
        .r_busy_i      (r_busy_o),
        .w_busy_i      (w_busy_o),
        .r_num_bytes_i (r_num_bytes),
        .w_num_bytes_i (w_num_bytes),
        .r_to_page_i   (r_to_page),
        .w_to_page_i   (w_to_page)
    );

    // ------------------------------------------------------------------------
    // Clock, readies and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Random or steady back-pressure
    always @(posedge clk) begin
        if (shake) begin
            r_ready <= 1'($urandom % 2);
            w_ready <= 1'($urandom % 2);
        end else begin
            r_ready <= ready_level;
            w_ready <= ready_level;
        end
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Timeout: transfers did not complete within %0d cycles", TimeoutCycles);
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Hold the request until ready_o takes it
    task automatic send_request(addr_t src, addr_t dst, len_t len, logic dec);
        @(posedge clk);
        src_addr <= src;
        dst_addr <= dst;
        length   <= len;
        decouple <= dec;
        valid    <= 1'b1;
        do begin
            @(posedge clk);
        end while (!ready);
        valid <= 1'b0;
    endtask

    task automatic random_transfer(logic dec, int min_len);
        send_request(addr_t'($urandom), addr_t'($urandom),
                     len_t'($urandom_range(MaxLength, min_len)), dec);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (r_busy || w_busy);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h599c));
        rst         = 1'b1;
        src_addr    = '0;
        dst_addr    = '0;
        length      = '0;
        decouple    = 1'b0;
        valid       = 1'b0;
        flush       = 1'b0;
        kill        = 1'b0;
        shake       = 1'b0;
        ready_level = 1'b0;
        test_id     = 0;
        repeat (5) @(posedge clk);
        rst         <= 1'b0;
        ready_level <= 1'b1;

        // Fits in one page on both sides
        test_id <= 1;
        send_request(24'h001004, 24'h002010, 16'd40, 1'b0);
        send_request(24'h000103, 24'h000402, 16'd13, 1'b0);
        wait_idle();

        // Paired bursts at the closer boundary
        test_id <= 2;
        repeat (4) random_transfer(1'b0, PageSize + 1);
        wait_idle();

        test_id <= 3;
        shake   <= 1'b1;
        repeat (4) random_transfer(1'b1, 1);
        wait_idle();

        test_id <= 4;
        repeat (4) random_transfer(1'b0, PageSize + 1);
        wait_idle();
        shake <= 1'b0;

        // Flush keeps a waiting request out, then holds emission mid transfer
        test_id <= 5;
        flush   <= 1'b1;
        fork
            send_request(24'h000200, 24'h000380, 16'd3000, 1'b0);
            begin
                repeat (4) @(posedge clk);
                flush <= 1'b0;
            end
        join
        repeat (2) @(posedge clk);
        flush <= 1'b1;
        repeat (6) @(posedge clk);
        flush <= 1'b0;
        wait_idle();

        // Drop a transfer, then start clean
        test_id <= 6;
        send_request(24'h000000, 24'h000000, 16'd3000, 1'b0);
        @(posedge clk);
        kill <= 1'b1;
        @(posedge clk);
        kill <= 1'b0;
        send_request(24'h000010, 24'h000c00, 16'd600, 1'b1);
        wait_idle();

        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Checked %0d read bursts and %0d write bursts, %0d errors, %0d assertion failures",
                 reads, writes, errors, dut.i_checker.fail_count);
        if (errors == 0 && dut.i_checker.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
legalizer_pkg.sv
burst_tracker.sv
legalizer_ctrl.sv
obi_read_request.sv
axi_write_request.sv
idma_legalizer.sv
legalizer_checker.sv
legalizer_monitor.sv
tb_legalizer.sv

// File: Makefile
# Verilator build and run of the burst legalizer testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_legalizer
FILELIST  ?= compile.f
SIM_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports errors"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
